// File: decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// instruction word and its fields
`define INSTR_W    32
`define OPCODE_W   6
`define REG_ADDR_W 5

// control word
`define ALUOP_W    6

`endif

// File: isaPkg.sv
`include "decode_macros.svh"

package isaPkg;

    // MIPS R-format view, I and J formats overlay the same bits
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] shamt;
        logic [`OPCODE_W-1:0]   funct;
    } instr_t;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_SPECIAL  = 6'b000000, OP_REGIMM = 6'b000001, OP_J     = 6'b000010,
        OP_JAL      = 6'b000011, OP_BEQ    = 6'b000100, OP_BNE   = 6'b000101,
        OP_BLEZ     = 6'b000110, OP_BGTZ   = 6'b000111, OP_ADDI  = 6'b001000,
        OP_ADDIU    = 6'b001001, OP_SLTI   = 6'b001010, OP_SLTIU = 6'b001011,
        OP_ANDI     = 6'b001100, OP_ORI    = 6'b001101, OP_XORI  = 6'b001110,
        OP_LUI      = 6'b001111, OP_LB     = 6'b100000, OP_LH    = 6'b100001,
        OP_LW       = 6'b100011, OP_SB     = 6'b101000, OP_SH    = 6'b101001,
        OP_SW       = 6'b101011, OP_SPECIAL2 = 6'b011100, OP_SPECIAL3 = 6'b011111
    } opcode_e;

    // funct codes under OP_SPECIAL
    typedef enum logic [`OPCODE_W-1:0] {
        FN_SLL  = 6'b000000, FN_SRL   = 6'b000010, FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000, FN_MOVZ  = 6'b001010, FN_MOVN = 6'b001011,
        FN_MFHI = 6'b010000, FN_MTHI  = 6'b010001, FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011, FN_MULT  = 6'b011000, FN_MULTU = 6'b011001,
        FN_ADD  = 6'b100000, FN_ADDU  = 6'b100001, FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100, FN_OR    = 6'b100101, FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111, FN_SLT   = 6'b101010, FN_SLTU = 6'b101011
    } funct_e;

    // special2 funct codes, they overlap the special ones
    localparam logic [`OPCODE_W-1:0] FN2_MADD = 6'b000000;
    localparam logic [`OPCODE_W-1:0] FN2_MUL  = 6'b000010;
    localparam logic [`OPCODE_W-1:0] FN2_MSUB = 6'b000100;

endpackage

// File: ctrlPkg.sv
`include "decode_macros.svh"

package ctrlPkg;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD  = 6'd0,  ALU_SUB   = 6'd1,  ALU_MUL  = 6'd2,  ALU_MULT = 6'd3,
        ALU_MADD = 6'd4,  ALU_MSUB  = 6'd5,  ALU_LUI  = 6'd6,  ALU_BGEZ = 6'd7,
        ALU_BEQ  = 6'd8,  ALU_BNE   = 6'd9,  ALU_BGTZ = 6'd10, ALU_BLEZ = 6'd11,
        ALU_BLTZ = 6'd12, ALU_J     = 6'd13, ALU_JAL  = 6'd14, ALU_AND  = 6'd15,
        ALU_OR   = 6'd16, ALU_NOR   = 6'd17, ALU_XOR  = 6'd18, ALU_SEH  = 6'd19,
        ALU_SLL  = 6'd20, ALU_SRL   = 6'd21, ALU_MOVN = 6'd22, ALU_MOVZ = 6'd23,
        ALU_ROTR = 6'd24, ALU_SRA   = 6'd25, ALU_SEB  = 6'd26, ALU_SLT  = 6'd27,
        ALU_MTHI = 6'd28, ALU_MTLO  = 6'd29, ALU_MFHI = 6'd30, ALU_MFLO = 6'd31,
        ALU_ADDU = 6'd32, ALU_MULTU = 6'd33, ALU_SLTU = 6'd34, ALU_JR   = 6'd35
    } aluOp_e;

    // access size for the load/store sign extender
    typedef enum logic [1:0] {
        MEM_WORD = 2'd0,
        MEM_HALF = 2'd1,
        MEM_BYTE = 2'd2
    } memSize_e;

    // one decoded instruction, as held in ID/EX
    typedef struct packed {
        logic     aluSrc;
        logic     regDst;
        logic     regWrite;
        aluOp_e   aluOp;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     aluSft;
        logic     zeroSrc;
        logic     branch;
        logic     jalSrc;
        logic     jzeroSrc;
        logic     jrSrc;
        memSize_e semCtrl;
    } ctrlWord_t;

endpackage

// File: rTypeDecoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module rTypeDecoder (
    input  isaPkg::instr_t     instr,
    output logic               hit,
    output ctrlPkg::ctrlWord_t ctrl
);

    // result goes to rd, drives regDst and regWrite together
    logic writeRd;

    always_comb begin
        hit = 1'b1;
        writeRd = 1'b0;
        ctrl = '{aluOp: ctrlPkg::ALU_ADD, semCtrl: ctrlPkg::MEM_WORD,
                 memToReg: 1'b1, jalSrc: 1'b1, default: 1'b0};

        // all-zero word is the nop and keeps the default word
        if (instr != {`INSTR_W{1'b0}}) begin
            case (instr.opcode)
                isaPkg::OP_SPECIAL: begin
                    // hi/lo writers and jr leave the register file alone
                    writeRd = !(instr.funct inside {isaPkg::FN_MULT, isaPkg::FN_MULTU,
                        isaPkg::FN_MTHI, isaPkg::FN_MTLO, isaPkg::FN_JR});
                    case (instr.funct)
                        isaPkg::FN_SLL: begin
                            ctrl.aluOp = ctrlPkg::ALU_SLL;
                            ctrl.aluSft = 1'b1;
                        end
                        isaPkg::FN_SRL: begin
                            // bit 21 picks rotr
                            ctrl.aluOp = instr.rs[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
                            ctrl.aluSft = 1'b1;
                        end
                        isaPkg::FN_SRA: begin
                            ctrl.aluOp = ctrlPkg::ALU_SRA;
                            ctrl.aluSft = 1'b1;
                        end
                        isaPkg::FN_SLLV:  ctrl.aluOp = ctrlPkg::ALU_SLL;
                        isaPkg::FN_SRLV: begin
                            // bit 6 picks rotrv
                            ctrl.aluOp = instr.shamt[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
                        end
                        isaPkg::FN_SRAV:  ctrl.aluOp = ctrlPkg::ALU_SRA;
                        isaPkg::FN_ADD:   ctrl.aluOp = ctrlPkg::ALU_ADD;
                        isaPkg::FN_ADDU:  ctrl.aluOp = ctrlPkg::ALU_ADDU;
                        isaPkg::FN_SUB:   ctrl.aluOp = ctrlPkg::ALU_SUB;
                        isaPkg::FN_AND:   ctrl.aluOp = ctrlPkg::ALU_AND;
                        isaPkg::FN_OR:    ctrl.aluOp = ctrlPkg::ALU_OR;
                        isaPkg::FN_NOR:   ctrl.aluOp = ctrlPkg::ALU_NOR;
                        isaPkg::FN_XOR:   ctrl.aluOp = ctrlPkg::ALU_XOR;
                        isaPkg::FN_SLT:   ctrl.aluOp = ctrlPkg::ALU_SLT;
                        isaPkg::FN_SLTU:  ctrl.aluOp = ctrlPkg::ALU_SLTU;
                        isaPkg::FN_MOVN:  ctrl.aluOp = ctrlPkg::ALU_MOVN;
                        isaPkg::FN_MOVZ:  ctrl.aluOp = ctrlPkg::ALU_MOVZ;
                        isaPkg::FN_MFHI:  ctrl.aluOp = ctrlPkg::ALU_MFHI;
                        isaPkg::FN_MFLO:  ctrl.aluOp = ctrlPkg::ALU_MFLO;
                        isaPkg::FN_MTHI:  ctrl.aluOp = ctrlPkg::ALU_MTHI;
                        isaPkg::FN_MTLO:  ctrl.aluOp = ctrlPkg::ALU_MTLO;
                        isaPkg::FN_MULT:  ctrl.aluOp = ctrlPkg::ALU_MULT;
                        isaPkg::FN_MULTU: ctrl.aluOp = ctrlPkg::ALU_MULTU;
                        isaPkg::FN_JR: begin
                            ctrl.aluOp = ctrlPkg::ALU_JR;
                            ctrl.branch = 1'b1;
                            ctrl.jrSrc = 1'b1;
                        end
                        default: hit = 1'b0;
                    endcase
                end
                isaPkg::OP_SPECIAL2: begin
                    // madd/msub accumulate into hi/lo only
                    writeRd = (instr.funct == isaPkg::FN2_MUL);
                    case (instr.funct)
                        isaPkg::FN2_MUL:  ctrl.aluOp = ctrlPkg::ALU_MUL;
                        isaPkg::FN2_MADD: ctrl.aluOp = ctrlPkg::ALU_MADD;
                        isaPkg::FN2_MSUB: ctrl.aluOp = ctrlPkg::ALU_MSUB;
                        default:          hit = 1'b0;
                    endcase
                end
                isaPkg::OP_SPECIAL3: begin
                    // bit 9 separates seh from seb
                    writeRd = 1'b1;
                    ctrl.aluOp = instr.shamt[3] ? ctrlPkg::ALU_SEH : ctrlPkg::ALU_SEB;
                end
                default: hit = 1'b0;
            endcase
        end

        ctrl.regDst = hit && writeRd;
        ctrl.regWrite = hit && writeRd;
    end

endmodule

// File: immDecoder.sv
`timescale 1ns/1ps

module immDecoder (
    input  isaPkg::instr_t     instr,
    output logic               hit,
    output ctrlPkg::ctrlWord_t ctrl
);

    // opcode low bits give the access size: 00 byte, 01 half, 11 word
    function automatic ctrlPkg::memSize_e sizeOf(input logic [1:0] sel);
        case (sel)
            2'b00:   return ctrlPkg::MEM_BYTE;
            2'b01:   return ctrlPkg::MEM_HALF;
            default: return ctrlPkg::MEM_WORD;
        endcase
    endfunction

    always_comb begin
        hit = 1'b1;
        ctrl = '{aluOp: ctrlPkg::ALU_ADD, semCtrl: ctrlPkg::MEM_WORD,
                 memToReg: 1'b1, jalSrc: 1'b1, default: 1'b0};

        // alu immediates write rt
        ctrl.regWrite = (instr.opcode inside {isaPkg::OP_ADDI, isaPkg::OP_ADDIU,
            isaPkg::OP_SLTI, isaPkg::OP_SLTIU, isaPkg::OP_ANDI, isaPkg::OP_ORI,
            isaPkg::OP_XORI, isaPkg::OP_LUI});

        case (instr.opcode)
            isaPkg::OP_ADDI:  ctrl.aluOp = ctrlPkg::ALU_ADD;
            isaPkg::OP_ADDIU: ctrl.aluOp = ctrlPkg::ALU_ADDU;
            isaPkg::OP_SLTI:  ctrl.aluOp = ctrlPkg::ALU_SLT;
            isaPkg::OP_LUI:   ctrl.aluOp = ctrlPkg::ALU_LUI;
            // zero-extended immediates
            isaPkg::OP_SLTIU: begin
                ctrl.aluOp = ctrlPkg::ALU_SLTU;
                ctrl.zeroSrc = 1'b1;
            end
            isaPkg::OP_ANDI: begin
                ctrl.aluOp = ctrlPkg::ALU_AND;
                ctrl.zeroSrc = 1'b1;
            end
            isaPkg::OP_ORI: begin
                ctrl.aluOp = ctrlPkg::ALU_OR;
                ctrl.zeroSrc = 1'b1;
            end
            isaPkg::OP_XORI: begin
                ctrl.aluOp = ctrlPkg::ALU_XOR;
                ctrl.zeroSrc = 1'b1;
            end
            // loads take the memory data, address is rs + offset
            isaPkg::OP_LB, isaPkg::OP_LH, isaPkg::OP_LW: begin
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b0;
                ctrl.semCtrl = sizeOf(instr.opcode[1:0]);
            end
            isaPkg::OP_SB, isaPkg::OP_SH, isaPkg::OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.semCtrl = sizeOf(instr.opcode[1:0]);
            end
            default: hit = 1'b0;
        endcase

        ctrl.aluSrc = hit;
    end

endmodule

// File: flowDecoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module flowDecoder (
    input  isaPkg::instr_t     instr,
    output logic               hit,
    output ctrlPkg::ctrlWord_t ctrl
);

    always_comb begin
        hit = 1'b1;
        ctrl = '{aluOp: ctrlPkg::ALU_ADD, semCtrl: ctrlPkg::MEM_WORD,
                 memToReg: 1'b1, jalSrc: 1'b1, default: 1'b0};

        // conditional branches compare against zero or rt
        ctrl.jzeroSrc = (instr.opcode inside {isaPkg::OP_REGIMM, isaPkg::OP_BEQ,
            isaPkg::OP_BNE, isaPkg::OP_BGTZ, isaPkg::OP_BLEZ});

        case (instr.opcode)
            isaPkg::OP_REGIMM: begin
                // rt selects the condition
                if (instr.rt == `REG_ADDR_W'(1)) begin
                    ctrl.aluOp = ctrlPkg::ALU_BGEZ;
                end else if (instr.rt == `REG_ADDR_W'(0)) begin
                    ctrl.aluOp = ctrlPkg::ALU_BLTZ;
                end else begin
                    hit = 1'b0;
                    ctrl.jzeroSrc = 1'b0;
                end
            end
            isaPkg::OP_BEQ:  ctrl.aluOp = ctrlPkg::ALU_BEQ;
            isaPkg::OP_BNE:  ctrl.aluOp = ctrlPkg::ALU_BNE;
            isaPkg::OP_BGTZ: ctrl.aluOp = ctrlPkg::ALU_BGTZ;
            isaPkg::OP_BLEZ: ctrl.aluOp = ctrlPkg::ALU_BLEZ;
            isaPkg::OP_J:    ctrl.aluOp = ctrlPkg::ALU_J;
            isaPkg::OP_JAL: begin
                // link address goes to $ra
                ctrl.aluOp = ctrlPkg::ALU_JAL;
                ctrl.regWrite = 1'b1;
                ctrl.jalSrc = 1'b0;
            end
            default: hit = 1'b0;
        endcase

        ctrl.branch = hit;
    end

endmodule

// File: controlStage.sv
`timescale 1ns/1ps

module controlStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  logic               rHit,
    input  logic               iHit,
    input  logic               fHit,
    input  ctrlPkg::ctrlWord_t rCtrl,
    input  ctrlPkg::ctrlWord_t iCtrl,
    input  ctrlPkg::ctrlWord_t fCtrl,
    output logic               ctrlValid,
    output ctrlPkg::ctrlWord_t ctrl
);

    // word for nop and unknown encodings
    localparam ctrlPkg::ctrlWord_t DefaultWord = '{aluOp: ctrlPkg::ALU_ADD,
        semCtrl: ctrlPkg::MEM_WORD, memToReg: 1'b1, jalSrc: 1'b1, default: 1'b0};

    ctrlPkg::ctrlWord_t nextWord;

    always_comb begin
        if (rHit) begin
            nextWord = rCtrl;
        end else if (iHit) begin
            nextWord = iCtrl;
        end else if (fHit) begin
            nextWord = fCtrl;
        end else begin
            nextWord = DefaultWord;
        end
    end

    ////////////////////////////////////////
    // ID/EX control register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl <= DefaultWord;
        end else begin
            ctrlValid <= instrValid;
            // bubble cycles keep the last word
            if (instrValid) begin
                ctrl <= nextWord;
            end
        end
    end

    ////////////////////////////////////////
    // decoder checks
    ////////////////////////////////////////
    // instruction classes are disjoint
    aHitsOnehot0: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({rHit, iHit, fHit}))
        else $error("more than one decoder hit");

    // jr is the only flow op in the register class
    aRTypeNoBranch: assert property (@(posedge clk) disable iff (!rstN)
        rHit |-> !(rCtrl.aluOp inside {ctrlPkg::ALU_BGEZ, ctrlPkg::ALU_BLTZ,
            ctrlPkg::ALU_BEQ, ctrlPkg::ALU_BNE, ctrlPkg::ALU_BGTZ, ctrlPkg::ALU_BLEZ,
            ctrlPkg::ALU_J, ctrlPkg::ALU_JAL}))
        else $error("r-type decoder produced a branch code");

    aImmMemExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(iCtrl.memRead && iCtrl.memWrite))
        else $error("load and store set together");

    aFlowLinkOnlyJal: assert property (@(posedge clk) disable iff (!rstN)
        (fHit && fCtrl.regWrite) |-> fCtrl.aluOp == ctrlPkg::ALU_JAL)
        else $error("flow decoder writes a register outside jal");

endmodule

// File: controller.sv
`timescale 1ns/1ps

module controller (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  isaPkg::instr_t     instr,
    output logic               ctrlValid,
    output ctrlPkg::ctrlWord_t ctrl
);

    logic               rHit;
    logic               iHit;
    logic               fHit;
    ctrlPkg::ctrlWord_t rCtrl;
    ctrlPkg::ctrlWord_t iCtrl;
    ctrlPkg::ctrlWord_t fCtrl;

    // class decoders
    rTypeDecoder uRType (.instr(instr), .hit(rHit), .ctrl(rCtrl));
    immDecoder   uImm   (.instr(instr), .hit(iHit), .ctrl(iCtrl));
    flowDecoder  uFlow  (.instr(instr), .hit(fHit), .ctrl(fCtrl));

    controlStage uStage (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .rHit       (rHit),
        .iHit       (iHit),
        .fHit       (fHit),
        .rCtrl      (rCtrl),
        .iCtrl      (iCtrl),
        .fCtrl      (fCtrl),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

endmodule

// File: decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// word for nop, bubbles after reset and unknown encodings
function automatic ctrlPkg::ctrlWord_t defaultWord();
    ctrlPkg::ctrlWord_t c;
    c = '0;
    c.aluOp = ctrlPkg::ALU_ADD;
    c.memToReg = 1'b1;
    c.jalSrc = 1'b1;
    c.semCtrl = ctrlPkg::MEM_WORD;
    return c;
endfunction

// expected ID/EX control word for one instruction
function automatic ctrlPkg::ctrlWord_t decodeExpected(input isaPkg::instr_t w);
    ctrlPkg::ctrlWord_t c;
    logic known;
    logic writesRd;
    c = defaultWord();
    known = 1'b1;
    writesRd = 1'b0;
    case (w.opcode)
        6'h00: begin
            // hi/lo writers and jr have no destination register
            writesRd = !(w.funct inside {6'h08, 6'h11, 6'h13, 6'h18, 6'h19});
            c.aluSft = w.funct inside {6'h00, 6'h02, 6'h03};
            c.branch = (w.funct == 6'h08);
            c.jrSrc = (w.funct == 6'h08);
            case (w.funct)
                6'h00: c.aluOp = ctrlPkg::ALU_SLL;
                6'h02: c.aluOp = w.rs[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
                6'h03: c.aluOp = ctrlPkg::ALU_SRA;
                6'h04: c.aluOp = ctrlPkg::ALU_SLL;
                6'h06: c.aluOp = w.shamt[0] ? ctrlPkg::ALU_ROTR : ctrlPkg::ALU_SRL;
                6'h07: c.aluOp = ctrlPkg::ALU_SRA;
                6'h08: c.aluOp = ctrlPkg::ALU_JR;
                6'h0A: c.aluOp = ctrlPkg::ALU_MOVZ;
                6'h0B: c.aluOp = ctrlPkg::ALU_MOVN;
                6'h10: c.aluOp = ctrlPkg::ALU_MFHI;
                6'h11: c.aluOp = ctrlPkg::ALU_MTHI;
                6'h12: c.aluOp = ctrlPkg::ALU_MFLO;
                6'h13: c.aluOp = ctrlPkg::ALU_MTLO;
                6'h18: c.aluOp = ctrlPkg::ALU_MULT;
                6'h19: c.aluOp = ctrlPkg::ALU_MULTU;
                6'h20: c.aluOp = ctrlPkg::ALU_ADD;
                6'h21: c.aluOp = ctrlPkg::ALU_ADDU;
                6'h22: c.aluOp = ctrlPkg::ALU_SUB;
                6'h24: c.aluOp = ctrlPkg::ALU_AND;
                6'h25: c.aluOp = ctrlPkg::ALU_OR;
                6'h26: c.aluOp = ctrlPkg::ALU_XOR;
                6'h27: c.aluOp = ctrlPkg::ALU_NOR;
                6'h2A: c.aluOp = ctrlPkg::ALU_SLT;
                6'h2B: c.aluOp = ctrlPkg::ALU_SLTU;
                default: known = 1'b0;
            endcase
        end
        6'h1C: begin
            writesRd = (w.funct == 6'h02);
            case (w.funct)
                6'h00: c.aluOp = ctrlPkg::ALU_MADD;
                6'h02: c.aluOp = ctrlPkg::ALU_MUL;
                6'h04: c.aluOp = ctrlPkg::ALU_MSUB;
                default: known = 1'b0;
            endcase
        end
        6'h1F: begin
            writesRd = 1'b1;
            // instruction bit 9 set means seh
            c.aluOp = w[9] ? ctrlPkg::ALU_SEH : ctrlPkg::ALU_SEB;
        end
        6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F: begin
            c.aluSrc = 1'b1;
            c.regWrite = 1'b1;
            // logical immediates and sltiu zero-extend
            c.zeroSrc = w.opcode inside {6'h0B, 6'h0C, 6'h0D, 6'h0E};
            case (w.opcode)
                6'h08: c.aluOp = ctrlPkg::ALU_ADD;
                6'h09: c.aluOp = ctrlPkg::ALU_ADDU;
                6'h0A: c.aluOp = ctrlPkg::ALU_SLT;
                6'h0B: c.aluOp = ctrlPkg::ALU_SLTU;
                6'h0C: c.aluOp = ctrlPkg::ALU_AND;
                6'h0D: c.aluOp = ctrlPkg::ALU_OR;
                6'h0E: c.aluOp = ctrlPkg::ALU_XOR;
                default: c.aluOp = ctrlPkg::ALU_LUI;
            endcase
        end
        6'h20, 6'h21, 6'h23: begin
            c.aluSrc = 1'b1;
            c.memRead = 1'b1;
            c.regWrite = 1'b1;
            c.memToReg = 1'b0;
        end
        6'h28, 6'h29, 6'h2B: begin
            c.aluSrc = 1'b1;
            c.memWrite = 1'b1;
        end
        6'h01: begin
            c.branch = 1'b1;
            c.jzeroSrc = 1'b1;
            if (w.rt == 5'd1) begin
                c.aluOp = ctrlPkg::ALU_BGEZ;
            end else if (w.rt == 5'd0) begin
                c.aluOp = ctrlPkg::ALU_BLTZ;
            end else begin
                known = 1'b0;
            end
        end
        6'h04, 6'h05, 6'h06, 6'h07: begin
            c.branch = 1'b1;
            c.jzeroSrc = 1'b1;
            case (w.opcode)
                6'h04: c.aluOp = ctrlPkg::ALU_BEQ;
                6'h05: c.aluOp = ctrlPkg::ALU_BNE;
                6'h06: c.aluOp = ctrlPkg::ALU_BLEZ;
                default: c.aluOp = ctrlPkg::ALU_BGTZ;
            endcase
        end
        6'h02: begin
            c.branch = 1'b1;
            c.aluOp = ctrlPkg::ALU_J;
        end
        6'h03: begin
            // jal links into a register
            c.branch = 1'b1;
            c.aluOp = ctrlPkg::ALU_JAL;
            c.regWrite = 1'b1;
            c.jalSrc = 1'b0;
        end
        default: known = 1'b0;
    endcase

    if (c.memRead || c.memWrite) begin
        case (w.opcode)
            6'h20, 6'h28: c.semCtrl = ctrlPkg::MEM_BYTE;
            6'h21, 6'h29: c.semCtrl = ctrlPkg::MEM_HALF;
            default:      c.semCtrl = ctrlPkg::MEM_WORD;
        endcase
    end
    if (writesRd) begin
        c.regDst = 1'b1;
        c.regWrite = 1'b1;
    end
    if (!known || w == '0) begin
        c = defaultWord();
    end
    return c;
endfunction

`endif

// File: controllerTb.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module controllerTb;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 5;
    localparam int NumIter = 2000;
    localparam logic [31:0] Seed = 32'h2ba9_334c;
    // bits 21, 9 and 6 select rotr, seh and rotrv
    localparam logic [31:0] VariantBits = 32'h0020_0240;

    localparam logic [5:0] KnownOps [24] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05,
        6'h06, 6'h07, 6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F,
        6'h1C, 6'h1F, 6'h20, 6'h21, 6'h23, 6'h28, 6'h29, 6'h2B};
    localparam logic [5:0] SpecialFns [24] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
        6'h08, 6'h0A, 6'h0B, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h20,
        6'h21, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B};
    localparam logic [5:0] Special2Fns [3] = '{6'h00, 6'h02, 6'h04};

    // what the DUT must show one cycle after an instruction
    typedef struct packed {
        logic               valid;
        ctrlPkg::ctrlWord_t word;
    } expect_t;

    logic               clk;
    logic               rstN;
    logic               instrValid;
    isaPkg::instr_t     instr;
    logic               ctrlValid;
    ctrlPkg::ctrlWord_t ctrl;

    logic [31:0]        rngState;
    ctrlPkg::ctrlWord_t heldWord;
    expect_t            pending[$];
    int                 cycles;
    int                 resetErrors;
    int                 validErrors;
    int                 wordErrors;

    `include "decodeModel.svh"

    controller u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((NumIter + ResetCycles + 10) * ClkPeriod);
        $display("watchdog expired at %0t, stimulus did not finish in time", $time);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift32(rngState);
        value = rngState;
    endtask

    ////////////////////////////////////////
    // check and drive, once per cycle
    ////////////////////////////////////////
    task automatic checkOutputs();
        expect_t want;
        if (pending.size() != 0) begin
            want = pending.pop_front();
            assert (ctrlValid === want.valid) else begin
                validErrors++;
                $display("FAILED %0t: ctrlValid %0b, expected %0b",
                    $time, ctrlValid, want.valid);
            end
            assert (ctrl === want.word) else begin
                wordErrors++;
                $display("FAILED %0t: ctrl %h, expected %h (instr %h)",
                    $time, ctrl, want.word, instr);
            end
        end
    endtask

    task automatic applyInstr(input logic [31:0] word, input logic valid);
        expect_t next;
        @(posedge clk);
        #1;
        checkOutputs();
        instr = word;
        instrValid = valid;
        // a bubble leaves the register holding its last word
        if (valid) begin
            heldWord = decodeExpected(word);
        end
        next.valid = valid;
        next.word = heldWord;
        pending.push_back(next);
        cycles++;
    endtask

    task automatic driveVariants(input logic [31:0] word);
        logic [31:0] idle;
        drawRandom(idle);
        applyInstr(word, 1'b1);
        applyInstr(word | VariantBits, 1'b1);
        applyInstr(idle, 1'b0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] sel;
        logic [31:0] word;
        int idx;
        rngState = Seed;
        cycles = 0;
        resetErrors = 0;
        validErrors = 0;
        wordErrors = 0;
        instr = '0;
        instrValid = 1'b0;
        rstN = 1'b0;

        repeat (ResetCycles) @(posedge clk);
        #1;
        assert (ctrlValid === 1'b0 && ctrl === defaultWord()) else begin
            resetErrors++;
            $display("FAILED %0t: outputs not at reset values (ctrlValid %0b, ctrl %h)",
                $time, ctrlValid, ctrl);
        end
        rstN = 1'b1;
        heldWord = defaultWord();
        pending.push_back({1'b0, heldWord});

        // every table entry, plain and with the variant bits
        for (int i = 0; i < 24; i++) begin
            if (KnownOps[i] == 6'h00) begin
                for (int j = 0; j < 24; j++) begin
                    driveVariants({6'h00, 20'h0, SpecialFns[j]});
                end
            end else if (KnownOps[i] == 6'h1C) begin
                for (int j = 0; j < 3; j++) begin
                    driveVariants({6'h1C, 20'h0, Special2Fns[j]});
                end
            end else if (KnownOps[i] == 6'h01) begin
                driveVariants({6'h01, 5'd0, 5'd0, 16'h0});
                driveVariants({6'h01, 5'd0, 5'd1, 16'h0});
            end else begin
                driveVariants({KnownOps[i], 26'h0});
            end
        end

        // unknown encodings
        applyInstr(32'hFC00_0000, 1'b1);
        applyInstr(32'h0000_0001, 1'b1);
        applyInstr({6'h01, 5'd0, 5'd2, 16'h0}, 1'b1);
        applyInstr(32'h7000_003F, 1'b1);

        // random mix of table entries and raw words
        while (cycles < NumIter) begin
            drawRandom(sel);
            drawRandom(word);
            if (sel[1:0] != 2'b00) begin
                idx = int'(sel[15:8]) % 24;
                word[31:26] = KnownOps[idx];
                if (word[31:26] == 6'h00) begin
                    idx = int'(sel[23:16]) % 24;
                    word[5:0] = SpecialFns[idx];
                end else if (word[31:26] == 6'h1C) begin
                    idx = int'(sel[25:24]) % 3;
                    word[5:0] = Special2Fns[idx];
                end else if (word[31:26] == 6'h01) begin
                    word[20:16] = {4'b0, sel[26]};
                end
            end
            applyInstr(word, sel[7:5] != 3'b000);
        end

        @(posedge clk);
        #1;
        checkOutputs();

        $display("%0d cycles, errors: %0d reset, %0d ctrlValid, %0d ctrl",
            cycles, resetErrors, validErrors, wordErrors);
        if (resetErrors + validErrors + wordErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
rTypeDecoder.sv
immDecoder.sv
flowDecoder.sv
controlStage.sv
controller.sv
controllerTb.sv

// File: run.sh
#!/bin/sh
# builds the controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module controllerTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
